/* include/mem_map.svh */
////////////////////////////////////////////////////////////////////////////
// System address map. Region ends are inclusive
// The L2 end depends on the bank count and is derived where it is needed
////////////////////////////////////////////////////////////////////////////

`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// Control registers
`define CTRL_BASE     32'h4000_0000
`define CTRL_END      32'h4000_FFFF

// L2 spans NumL2Banks banks of this size
`define L2_BASE       32'h8000_0000
`define L2_BANK_BYTES 32'h0000_0400

// Boot ROM window, larger than the image itself
`define BOOT_BASE     32'hA000_0000
`define BOOT_END      32'hA000_FFFF

`endif

/* design/mempool_lite_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Widths and bus types for a single host with 32-bit words
// L2 geometry assumes at most 1 << L2BankSelWidth banks
////////////////////////////////////////////////////////////////////////////

`include "mem_map.svh"

package mempool_lite_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned OffWidth  = $clog2(BeWidth);  // Byte offset inside a word

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2RowWidth     = $clog2(L2BankNumWords);
  localparam int unsigned L2BankSelWidth = 2;
  localparam int unsigned CtrlIdxWidth   = 4;

  typedef struct packed {
    logic [AddrWidth-L2RowWidth-L2BankSelWidth-OffWidth-1:0] upper;
    logic [L2RowWidth-1:0]                                   row;
    logic [L2BankSelWidth-1:0]                               bank;  // Word interleave
    logic [OffWidth-1:0]                                     offset;
  } l2_addr_t;

  typedef struct packed {
    logic [AddrWidth-CtrlIdxWidth-OffWidth-1:0] upper;
    logic [CtrlIdxWidth-1:0]                    idx;
    logic [OffWidth-1:0]                        offset;
  } ctrl_addr_t;

  // Same address word seen by L2 and by the control block
  typedef union packed {
    l2_addr_t   l2;
    ctrl_addr_t ctrl;
  } addr_u;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_u addr;
    data_t wdata;
    be_t   be;
  } bus_req_t;

  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_u addr;
    data_t wdata;
    be_t   be;
  } mem_req_t;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  typedef logic [CtrlIdxWidth-1:0] ctrl_idx_t;

  localparam ctrl_idx_t CtrlWakeUp   = 4'd0;
  localparam ctrl_idx_t CtrlEoc      = 4'd1;
  localparam ctrl_idx_t CtrlBootAddr = 4'd2;
  localparam ctrl_idx_t CtrlL2Size   = 4'd3;
  localparam ctrl_idx_t CtrlNumCores = 4'd4;

  localparam addr_t CtrlBase    = `CTRL_BASE;
  localparam addr_t CtrlEnd     = `CTRL_END;
  localparam addr_t L2Base      = `L2_BASE;
  localparam addr_t L2BankBytes = `L2_BANK_BYTES;
  localparam addr_t BootBase    = `BOOT_BASE;
  localparam addr_t BootEnd     = `BOOT_END;

  // Full L2 window with every bank fitted
  localparam addr_t L2SizeBytes = (2 ** L2BankSelWidth) * L2BankBytes;

  localparam int unsigned BootromWords = 16;

  // Parks every hart in wfi until woken, then jumps to the L2 base
  localparam data_t BootromImage [BootromWords] = '{
    32'hf140_2573, 32'h0000_0297, 32'h0382_8293, 32'h1050_0073,
    32'h8000_02b7, 32'h0002_8067, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'hff5f_f06f, 32'h0000_0000
  };

endpackage

/* design/l2_bank.sv */
////////////////////////////////////////////////////////////////////////////
// Single-port SRAM bank. Read data holds until the next read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module l2_bank (
  input  logic                                    clk_i,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  logic [mempool_lite_pkg::L2RowWidth-1:0] addr_i,
  input  mempool_lite_pkg::data_t                 wdata_i,
  input  mempool_lite_pkg::be_t                   be_i,
  output mempool_lite_pkg::data_t                 rdata_o
);

  import mempool_lite_pkg::*;

  data_t mem_q [L2BankNumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (be_i[b]) begin  // Byte lane update
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule : l2_bank

/* design/l2_memory.sv */
////////////////////////////////////////////////////////////////////////////
// Word-interleaved L2. Consecutive words land in consecutive banks
// NumL2Banks must be 1, 2 or 4. Contents are undefined after power-up
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module l2_memory #(
  parameter int unsigned NumL2Banks = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mempool_lite_pkg::mem_req_t mem_req_i,
  output mempool_lite_pkg::data_t    rdata_o
);

  import mempool_lite_pkg::*;

  localparam int unsigned WordIdxWidth = L2RowWidth + L2BankSelWidth;

  logic [WordIdxWidth-1:0]   word_idx;
  logic [L2BankSelWidth-1:0] bank_sel_d, bank_sel_q;
  logic [L2RowWidth-1:0]     row;
  logic [NumL2Banks-1:0]     bank_req;
  data_t [NumL2Banks-1:0]    bank_rdata;

  // Row and bank fields together give the word index inside the L2 window
  assign word_idx = {mem_req_i.addr.l2.row, mem_req_i.addr.l2.bank};

  // Fewer banks means deeper use of each bank
  assign bank_sel_d = L2BankSelWidth'(word_idx % NumL2Banks);
  assign row        = L2RowWidth'(word_idx / NumL2Banks);

  for (genvar i = 0; i < NumL2Banks; i++) begin : gen_banks
    assign bank_req[i] = mem_req_i.req && (bank_sel_d == L2BankSelWidth'(i));

    l2_bank i_l2_bank (
      .clk_i  (clk_i          ),
      .req_i  (bank_req[i]    ),
      .we_i   (mem_req_i.we   ),
      .addr_i (row            ),
      .wdata_i(mem_req_i.wdata),
      .be_i   (mem_req_i.be   ),
      .rdata_o(bank_rdata[i]  )
    );
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bank_sel_q <= '0;
    end else if (mem_req_i.req) begin
      bank_sel_q <= bank_sel_d;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule : l2_memory

/* design/bootrom.sv */
////////////////////////////////////////////////////////////////////////////
// Fixed boot image, read only. Offsets past the image wrap around
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bootrom (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  mempool_lite_pkg::addr_t addr_i,
  output mempool_lite_pkg::data_t rdata_o
);

  import mempool_lite_pkg::*;

  localparam int unsigned IdxWidth = $clog2(BootromWords);

  logic [IdxWidth-1:0] word_idx;

  // Word address bits, upper bits dropped
  assign word_idx = addr_i[OffWidth +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= BootromImage[word_idx];
    end
  end

endmodule : bootrom

/* design/ctrl_registers.sv */
////////////////////////////////////////////////////////////////////////////
// Control registers. Writes are full words and byte enables are ignored
// Unused indices read zero. NumCores must be 1 to 32
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_registers #(
  parameter int unsigned             NumCores = 8,
  parameter mempool_lite_pkg::addr_t BootAddr = 32'hA000_0000
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mempool_lite_pkg::mem_req_t mem_req_i,
  output mempool_lite_pkg::data_t    rdata_o,
  output logic [NumCores-1:0]        wake_up_o,
  output logic                       eoc_valid_o
);

  import mempool_lite_pkg::*;

  ctrl_idx_t           idx;
  logic                wr_en;
  logic                rd_en;
  logic [NumCores-1:0] wake_up_q;
  data_t               eoc_q;
  data_t               rdata_d;
  data_t               rdata_q;

  assign idx   = mem_req_i.addr.ctrl.idx;
  assign wr_en = mem_req_i.req && mem_req_i.we;
  assign rd_en = mem_req_i.req && !mem_req_i.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wake_up_q <= '0;
      eoc_q     <= '0;
    end else if (wr_en) begin
      case (idx)
        CtrlWakeUp: wake_up_q <= mem_req_i.wdata[NumCores-1:0];  // One bit per core
        CtrlEoc:    eoc_q     <= mem_req_i.wdata;
        default: ;  // Read-only and unused indices
      endcase
    end
  end

  always_comb begin
    case (idx)
      CtrlWakeUp:   rdata_d = data_t'(wake_up_q);
      CtrlEoc:      rdata_d = eoc_q;
      CtrlBootAddr: rdata_d = BootAddr;
      CtrlL2Size:   rdata_d = L2SizeBytes;
      CtrlNumCores: rdata_d = data_t'(NumCores);
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o     = rdata_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_q[0];  // Bit 0 flags end of computation

endmodule : ctrl_registers

/* design/sys_bus_demux.sv */
////////////////////////////////////////////////////////////////////////////
// Region decode for one requester. Targets answer one cycle after a strobe
// Unmapped accesses and boot ROM writes reach no target and return err
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_demux #(
  parameter int unsigned NumL2Banks = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mempool_lite_pkg::bus_req_t bus_req_i,
  output mempool_lite_pkg::bus_rsp_t bus_rsp_o,
  output mempool_lite_pkg::mem_req_t l2_req_o,
  output mempool_lite_pkg::mem_req_t boot_req_o,
  output mempool_lite_pkg::mem_req_t ctrl_req_o,
  input  mempool_lite_pkg::data_t    l2_rdata_i,
  input  mempool_lite_pkg::data_t    boot_rdata_i,
  input  mempool_lite_pkg::data_t    ctrl_rdata_i
);

  import mempool_lite_pkg::*;

  localparam addr_t L2End = L2Base + addr_t'(NumL2Banks) * L2BankBytes - 1;

  addr_t    req_addr;
  target_e  tgt_d, tgt_q;
  logic     err_d, err_q;
  logic     valid_q;
  logic     we_q;
  mem_req_t fwd_req;

  assign req_addr = addr_t'(bus_req_i.addr);

  always_comb begin
    if (req_addr >= CtrlBase && req_addr <= CtrlEnd) begin
      tgt_d = TgtCtrl;
    end else if (req_addr >= L2Base && req_addr <= L2End) begin
      tgt_d = TgtL2;
    end else if (req_addr >= BootBase && req_addr <= BootEnd) begin
      tgt_d = TgtBootrom;
    end else begin
      tgt_d = TgtNone;
    end
  end

  assign err_d = (tgt_d == TgtNone) || (tgt_d == TgtBootrom && bus_req_i.we);

  // Payload goes to every target, only the strobe is steered
  always_comb begin
    fwd_req        = '0;
    fwd_req.we     = bus_req_i.we;
    fwd_req.addr   = bus_req_i.addr;
    fwd_req.wdata  = bus_req_i.wdata;
    fwd_req.be     = bus_req_i.be;
    l2_req_o       = fwd_req;
    boot_req_o     = fwd_req;
    ctrl_req_o     = fwd_req;
    l2_req_o.req   = bus_req_i.req && (tgt_d == TgtL2);
    boot_req_o.req = bus_req_i.req && (tgt_d == TgtBootrom) && !bus_req_i.we;
    ctrl_req_o.req = bus_req_i.req && (tgt_d == TgtCtrl);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
      tgt_q   <= TgtNone;
    end else begin
      valid_q <= bus_req_i.req;
      err_q   <= bus_req_i.req && err_d;
      we_q    <= bus_req_i.we;
      tgt_q   <= tgt_d;
    end
  end

  always_comb begin
    bus_rsp_o        = '0;
    bus_rsp_o.rvalid = valid_q;
    bus_rsp_o.err    = err_q;
    if (valid_q && !err_q && !we_q) begin  // Writes and errors return zero
      case (tgt_q)
        TgtL2:      bus_rsp_o.rdata = l2_rdata_i;
        TgtBootrom: bus_rsp_o.rdata = boot_rdata_i;
        TgtCtrl:    bus_rsp_o.rdata = ctrl_rdata_i;
        default:    bus_rsp_o.rdata = '0;
      endcase
    end
  end

endmodule : sys_bus_demux

/* design/mem_system.sv */
////////////////////////////////////////////////////////////////////////////
// Memory subsystem top. One host request per cycle and no back-pressure
// Every response appears exactly one cycle after its request strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_system #(
  parameter int unsigned             NumL2Banks = 4,  // 1, 2 or 4
  parameter int unsigned             NumCores   = 8,  // 1 to 32
  parameter mempool_lite_pkg::addr_t BootAddr   = 32'hA000_0000
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mempool_lite_pkg::bus_req_t bus_req_i,
  output mempool_lite_pkg::bus_rsp_t bus_rsp_o,
  output logic [NumCores-1:0]        wake_up_o,
  output logic                       eoc_valid_o
);

  import mempool_lite_pkg::*;

  mem_req_t l2_req;
  mem_req_t boot_req;
  mem_req_t ctrl_req;
  data_t    l2_rdata;
  data_t    boot_rdata;
  data_t    ctrl_rdata;

  sys_bus_demux #(
    .NumL2Banks(NumL2Banks)
  ) i_sys_bus_demux (
    .clk_i       (clk_i     ),
    .arst_n_i    (arst_n_i  ),
    .bus_req_i   (bus_req_i ),
    .bus_rsp_o   (bus_rsp_o ),
    .l2_req_o    (l2_req    ),
    .boot_req_o  (boot_req  ),
    .ctrl_req_o  (ctrl_req  ),
    .l2_rdata_i  (l2_rdata  ),
    .boot_rdata_i(boot_rdata),
    .ctrl_rdata_i(ctrl_rdata)
  );

  l2_memory #(
    .NumL2Banks(NumL2Banks)
  ) i_l2_memory (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .mem_req_i(l2_req  ),
    .rdata_o  (l2_rdata)
  );

  bootrom i_bootrom (
    .clk_i  (clk_i                ),
    .req_i  (boot_req.req         ),
    .addr_i (addr_t'(boot_req.addr)),
    .rdata_o(boot_rdata           )
  );

  ctrl_registers #(
    .NumCores(NumCores),
    .BootAddr(BootAddr)
  ) i_ctrl_registers (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .mem_req_i  (ctrl_req   ),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mem_system

/* verification/tb_clk_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset. Reset is released on a rising clock edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule : tb_clk_gen

/* verification/tb_mem_system.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for mem_system with the default parameters
// Responses are sampled on the falling edge, one cycle after each strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mem_map.svh"

module tb_mem_system;

  import mempool_lite_pkg::*;

  localparam int unsigned NumL2Banks = 4;
  localparam int unsigned NumCores   = 8;
  localparam addr_t       BootAddr   = 32'hA000_0000;
  localparam int unsigned ClkPeriod  = 8;
  localparam int unsigned L2Words    = NumL2Banks * L2BankNumWords;

  typedef struct {
    int                  test_id;
    logic                req;
    logic                we;
    addr_t               addr;
    data_t               wdata;
    be_t                 be;
    data_t               exp_rdata;
    logic                exp_err;
    logic [NumCores-1:0] exp_wake;  // Register state after this entry
    logic                exp_eoc;
  } entry_t;

  logic                clk;
  logic                arst_n;
  bus_req_t            bus_req;
  bus_rsp_t            bus_rsp;
  logic [NumCores-1:0] wake_up;
  logic                eoc_valid;

  entry_t              stim_q[$];
  int                  pending_q[$];
  data_t               l2_model [L2Words];
  logic [NumCores-1:0] wake_model  = '0;
  data_t               eoc_model   = '0;
  logic [31:0]         rng_state   = 32'd11;
  logic                table_ready = 1'b0;
  string               test_names [1:6] = '{"reset state", "l2 byte enables and interleave",
                                            "back-to-back traffic", "boot rom",
                                            "unmapped addresses", "control registers"};
  int                  test_errors [1:6] = '{default: 0};
  int                  cur_test;
  int                  check_count;
  int                  error_count;
  int                  tests_run;
  int                  tests_passed;

  tb_clk_gen #(.PeriodNs(ClkPeriod), .ResetCycles(3)) i_clk_gen (
    .clk_o   (clk   ),
    .arst_n_o(arst_n)
  );

  mem_system #(
    .NumL2Banks(NumL2Banks),
    .NumCores  (NumCores  ),
    .BootAddr  (BootAddr  )
  ) UUT (
    .clk_i      (clk      ),
    .arst_n_i   (arst_n   ),
    .bus_req_i  (bus_req  ),
    .bus_rsp_o  (bus_rsp  ),
    .wake_up_o  (wake_up  ),
    .eoc_valid_o(eoc_valid)
  );

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic add_entry(input int id, input logic req, input logic we, input addr_t addr,
                           input data_t wdata, input be_t be, input data_t exp_rdata,
                           input logic exp_err);
    entry_t e;
    e = '{id, req, we, addr, wdata, be, exp_rdata, exp_err, wake_model, eoc_model[0]};
    stim_q.push_back(e);
  endtask

  task automatic l2_write(input int id, input int word, input data_t data, input be_t be);
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) l2_model[word][8*b +: 8] = data[8*b +: 8];
    end
    add_entry(id, 1'b1, 1'b1, `L2_BASE + 4 * word, data, be, '0, 1'b0);
  endtask

  task automatic l2_read(input int id, input int word);
    add_entry(id, 1'b1, 1'b0, `L2_BASE + 4 * word, '0, 4'hF, l2_model[word], 1'b0);
  endtask

  // Only wake-up and end-of-computation take full-word writes
  task automatic ctrl_write(input int id, input ctrl_idx_t idx, input data_t data, input be_t be);
    if (idx == CtrlWakeUp) wake_model = data[NumCores-1:0];
    if (idx == CtrlEoc) eoc_model = data;
    add_entry(id, 1'b1, 1'b1, `CTRL_BASE + 4 * 32'(idx), data, be, '0, 1'b0);
  endtask

  task automatic ctrl_read(input int id, input ctrl_idx_t idx, input data_t exp);
    add_entry(id, 1'b1, 1'b0, `CTRL_BASE + 4 * 32'(idx), '0, 4'hF, exp, 1'b0);
  endtask

  task automatic boot_read(input int id, input addr_t addr);
    add_entry(id, 1'b1, 1'b0, addr, '0, 4'hF, BootromImage[(addr >> 2) % BootromWords], 1'b0);
  endtask

  task automatic build_table();
    int    w;
    addr_t past_l2;
    past_l2 = `L2_BASE + NumL2Banks * `L2_BANK_BYTES;
    // Low words and the top of L2 in every bank
    for (int k = 0; k < 12; k++) l2_write(2, (k < 8) ? k : L2Words - 12 + k, next_random(), 4'hF);
    for (int k = 0; k < 12; k++) begin
      w = (k < 8) ? k : L2Words - 12 + k;
      l2_write(2, w, next_random(), be_t'(next_random()));
    end
    for (int k = 0; k < 12; k++) l2_read(2, (k < 8) ? k : L2Words - 12 + k);
    add_entry(2, 1'b0, 1'b0, '0, '0, '0, '0, 1'b0);
    for (int k = 0; k < 8; k++) begin
      w = 100 + 5 * k;
      l2_write(3, w, next_random(), 4'hF);
      l2_read(3, w);
      boot_read(3, `BOOT_BASE + 4 * k);
      l2_write(3, w, next_random(), be_t'(next_random()));
      l2_read(3, w);
      if (k % 3 == 0) add_entry(3, 1'b0, 1'b0, '0, '0, '0, '0, 1'b0);  // Gap
    end
    for (int k = 0; k < BootromWords; k++) boot_read(4, `BOOT_BASE + 4 * k);
    boot_read(4, `BOOT_BASE + 32'h4C);  // Wraps onto the image
    boot_read(4, `BOOT_END - 3);
    add_entry(4, 1'b1, 1'b1, `BOOT_BASE + 8, 32'hDEAD_BEEF, 4'hF, '0, 1'b1);
    boot_read(4, `BOOT_BASE + 8);
    add_entry(5, 1'b1, 1'b0, 32'h2000_0000, '0, 4'hF, '0, 1'b1);
    add_entry(5, 1'b1, 1'b1, 32'h2000_0000, 32'h1234_5678, 4'hF, '0, 1'b1);
    add_entry(5, 1'b1, 1'b0, past_l2, '0, 4'hF, '0, 1'b1);
    l2_read(5, L2Words - 1);
    add_entry(5, 1'b1, 1'b0, `CTRL_END + 1, '0, 4'hF, '0, 1'b1);
    add_entry(5, 1'b1, 1'b0, 32'hFFFF_FFFC, '0, 4'hF, '0, 1'b1);
    ctrl_write(6, CtrlWakeUp, 32'hFFFF_FFA5, 4'hF);
    ctrl_read(6, CtrlWakeUp, data_t'(wake_model));
    ctrl_write(6, CtrlWakeUp, 32'h0000_013C, 4'h1);  // Enables do not matter here
    ctrl_read(6, CtrlWakeUp, data_t'(wake_model));
    ctrl_write(6, CtrlEoc, 32'h1, 4'hF);
    ctrl_read(6, CtrlEoc, eoc_model);
    ctrl_write(6, CtrlEoc, 32'h0, 4'hF);
    ctrl_read(6, CtrlEoc, eoc_model);
    for (int r = 0; r < 2; r++) begin
      ctrl_read(6, CtrlBootAddr, BootAddr);
      ctrl_read(6, CtrlL2Size, NumL2Banks * `L2_BANK_BYTES);
      ctrl_read(6, CtrlNumCores, NumCores);
      ctrl_write(6, CtrlBootAddr, 32'h5555_AAAA, 4'hF);
      ctrl_write(6, CtrlL2Size, 32'h5555_AAAA, 4'hF);
      ctrl_write(6, CtrlNumCores, 32'h5555_AAAA, 4'hF);
    end
    ctrl_read(6, 4'd9, '0);
    ctrl_write(6, CtrlWakeUp, '0, 4'hF);
    add_entry(6, 1'b0, 1'b0, '0, '0, '0, '0, 1'b0);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h (test %0d at %0t)",
               name, got, exp, cur_test, $time);
      error_count++;
      test_errors[cur_test]++;
    end
  endtask

  task automatic report_test(input int id);
    tests_run++;
    if (test_errors[id] == 0) tests_passed++;
    $display("[test %0d] %s: %s, %0d errors", id, test_names[id],
             (test_errors[id] == 0) ? "pass" : "fail", test_errors[id]);
  endtask

  task automatic check_entry(input int idx);
    entry_t e;
    e        = stim_q[idx];
    cur_test = e.test_id;
    check_value("bus_rsp_o.rvalid", 32'(bus_rsp.rvalid), 32'(e.req));
    if (e.req) begin
      check_value("bus_rsp_o.err", 32'(bus_rsp.err), 32'(e.exp_err));
      check_value("bus_rsp_o.rdata", bus_rsp.rdata, e.exp_rdata);
    end
    check_value("wake_up_o", 32'(wake_up), 32'(e.exp_wake));
    check_value("eoc_valid_o", 32'(eoc_valid), 32'(e.exp_eoc));
    if (idx == stim_q.size() - 1 || stim_q[idx + 1].test_id != e.test_id) report_test(e.test_id);
  endtask

  task automatic check_idle_state();
    check_value("bus_rsp_o.rvalid", 32'(bus_rsp.rvalid), '0);
    check_value("bus_rsp_o.err", 32'(bus_rsp.err), '0);
    check_value("wake_up_o", 32'(wake_up), '0);
    check_value("eoc_valid_o", 32'(eoc_valid), '0);
  endtask

  initial begin
    bus_req_t req_v;
    entry_t   e;
    bus_req = '0;
    build_table();
    table_ready = 1'b1;
    cur_test    = 1;
    @(posedge clk);
    @(negedge clk);
    check_idle_state();  // Still in reset
    @(posedge arst_n);
    @(negedge clk);
    check_idle_state();
    report_test(1);
    for (int i = 0; i <= stim_q.size(); i++) begin
      @(posedge clk);
      req_v = '0;
      if (i < stim_q.size()) begin
        e           = stim_q[i];
        req_v.req   = e.req;
        req_v.we    = e.we;
        req_v.addr  = addr_u'(e.addr);
        req_v.wdata = e.wdata;
        req_v.be    = e.be;
      end
      bus_req <= req_v;
      @(negedge clk);
      if (pending_q.size() > 0) check_entry(pending_q.pop_front());
      if (i < stim_q.size()) pending_q.push_back(i);
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_passed, tests_run - tests_passed, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #((stim_q.size() + 20) * ClkPeriod);
    $display("Watchdog timeout: the table did not finish within %0d cycles", stim_q.size() + 20);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule : tb_mem_system

/* mempool_lite.f */
+incdir+include
design/mempool_lite_pkg.sv
design/l2_bank.sv
design/l2_memory.sv
design/bootrom.sv
design/ctrl_registers.sv
design/sys_bus_demux.sv
design/mem_system.sv
verification/tb_clk_gen.sv
verification/tb_mem_system.sv
